// File: hdl/uncore_consts.svh
`ifndef UNCORE_CONSTS_SVH
`define UNCORE_CONSTS_SVH

// physical address bits
`define PA_WIDTH 32

// log2 of the number of memory request tags
`define LG_L2_REQ_TAGS 2

// one level-two cache line
`define L2_CL_BITS 128

`define MEM_OPCODE_WIDTH 4

// pc of the access that caused the request
`define PC_WIDTH 64

`endif

// File: hdl/uncore_pkg.sv
`include "uncore_consts.svh"

package uncore_pkg;

   typedef logic [`PA_WIDTH-1:0] pa_t;

   typedef logic [`LG_L2_REQ_TAGS-1:0] req_tag_t;

   typedef logic [`L2_CL_BITS-1:0] cl_data_t;

   typedef logic [`MEM_OPCODE_WIDTH-1:0] mem_opcode_t;

   typedef logic [`PC_WIDTH-1:0] pc_t;

   // one bit wider than a tag
   typedef logic [`LG_L2_REQ_TAGS:0] inflight_t;

   // GOT_L1D and GOT_L1I name the cache that has already finished
   typedef enum logic [2:0] {
      FLUSH_IDLE       = 3'd0,
      WAIT_FOR_L1D_L1I = 3'd1,
      GOT_L1D          = 3'd2,
      GOT_L1I          = 3'd3,
      FLUSH_L2         = 3'd4
   } flush_state_t;

endpackage

// File: hdl/flush_sequencer.sv
`timescale 1ns/1ns

module flush_sequencer (
   input  logic clk,
   input  logic reset,
   input  logic flush_req_l1i,
   input  logic flush_req_l1d,
   input  logic l1i_flush_complete,
   input  logic l1d_flush_complete,
   input  logic l2_flush_complete,
   output logic in_flush_mode,
   output logic flush_l2
);

   uncore_pkg::flush_state_t r_state;
   uncore_pkg::flush_state_t n_state;
   logic r_flush;
   logic n_flush;
   logic r_flush_l2;
   logic n_flush_l2;

   assign in_flush_mode = r_flush;
   assign flush_l2 = r_flush_l2;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= uncore_pkg::FLUSH_IDLE;
         r_flush <= 1'b0;
         r_flush_l2 <= 1'b0;
      end
      else
      begin
         r_state <= n_state;
         r_flush <= n_flush;
         r_flush_l2 <= n_flush_l2;
      end
   end

   always_comb
   begin
      n_state = r_state;
      n_flush = r_flush;
      // single cycle strobe
      n_flush_l2 = 1'b0;

      case (r_state)
         uncore_pkg::FLUSH_IDLE:
         begin
            if (flush_req_l1i && flush_req_l1d)
            begin
               n_state = uncore_pkg::WAIT_FOR_L1D_L1I;
               n_flush = 1'b1;
            end
            else if (flush_req_l1i)
            begin
               // no data cache flush owed
               n_state = uncore_pkg::GOT_L1D;
               n_flush = 1'b1;
            end
            else if (flush_req_l1d)
            begin
               n_state = uncore_pkg::GOT_L1I;
               n_flush = 1'b1;
            end
         end
         uncore_pkg::WAIT_FOR_L1D_L1I:
         begin
            if (l1d_flush_complete && l1i_flush_complete)
            begin
               n_state = uncore_pkg::FLUSH_L2;
               n_flush_l2 = 1'b1;
            end
            else if (l1d_flush_complete)
            begin
               n_state = uncore_pkg::GOT_L1D;
            end
            else if (l1i_flush_complete)
            begin
               n_state = uncore_pkg::GOT_L1I;
            end
         end
         uncore_pkg::GOT_L1D:
         begin
            if (l1i_flush_complete)
            begin
               n_state = uncore_pkg::FLUSH_L2;
               n_flush_l2 = 1'b1;
            end
         end
         uncore_pkg::GOT_L1I:
         begin
            if (l1d_flush_complete)
            begin
               n_state = uncore_pkg::FLUSH_L2;
               n_flush_l2 = 1'b1;
            end
         end
         uncore_pkg::FLUSH_L2:
         begin
            // flush mode ends with the level-two completion
            if (l2_flush_complete)
            begin
               n_state = uncore_pkg::FLUSH_IDLE;
               n_flush = 1'b0;
            end
         end
         default:
         begin
            n_state = uncore_pkg::FLUSH_IDLE;
            n_flush = 1'b0;
         end
      endcase
   end

endmodule

// File: hdl/mem_req_queue.sv
`timescale 1ns/1ns
`include "uncore_consts.svh"

module mem_req_queue (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   l2_req_valid,
   input  uncore_pkg::pa_t         l2_req_addr,
   input  uncore_pkg::req_tag_t    l2_req_tag,
   input  uncore_pkg::cl_data_t    l2_req_store_data,
   input  uncore_pkg::mem_opcode_t l2_req_opcode,
   input  uncore_pkg::pc_t         l2_req_pc,
   input  logic                   mem_req_gnt,
   input  logic                   mem_rsp_valid,
   output logic                   mem_req_valid,
   output uncore_pkg::pa_t         mem_req_addr,
   output uncore_pkg::req_tag_t    mem_req_tag,
   output uncore_pkg::cl_data_t    mem_req_store_data,
   output uncore_pkg::mem_opcode_t mem_req_opcode,
   output uncore_pkg::pc_t         mem_req_pc,
   output uncore_pkg::inflight_t   inflight
);

   // twice the tag count, so the producer can never overrun it
   localparam int LG_DEPTH = `LG_L2_REQ_TAGS + 1;
   localparam int DEPTH = 1 << LG_DEPTH;

   typedef struct packed {
      uncore_pkg::pa_t         addr;
      uncore_pkg::req_tag_t    tag;
      uncore_pkg::cl_data_t    data;
      uncore_pkg::mem_opcode_t opcode;
      uncore_pkg::pc_t         pc;
   } entry_t;

   entry_t mem_q [DEPTH];
   entry_t t_entry;
   entry_t head_entry;

   // extra msb is the wrap bit
   logic [LG_DEPTH:0] r_head_ptr;
   logic [LG_DEPTH:0] r_tail_ptr;
   logic [LG_DEPTH-1:0] head_idx;
   logic [LG_DEPTH-1:0] tail_idx;
   logic empty;

   uncore_pkg::inflight_t r_inflight;
   uncore_pkg::inflight_t n_inflight;

   assign head_idx = r_head_ptr[LG_DEPTH-1:0];
   assign tail_idx = r_tail_ptr[LG_DEPTH-1:0];
   assign empty = (r_head_ptr == r_tail_ptr);

   always_comb
   begin
      t_entry.addr = l2_req_addr;
      t_entry.tag = l2_req_tag;
      t_entry.data = l2_req_store_data;
      t_entry.opcode = l2_req_opcode;
      t_entry.pc = l2_req_pc;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_head_ptr <= '0;
         r_tail_ptr <= '0;
      end
      else
      begin
         if (l2_req_valid)
            r_tail_ptr <= r_tail_ptr + 1'b1;
         if (mem_req_gnt)
            r_head_ptr <= r_head_ptr + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (l2_req_valid)
         mem_q[tail_idx] <= t_entry;
   end

   // head goes straight to the memory port
   assign head_entry = mem_q[head_idx];
   assign mem_req_valid = !empty;
   assign mem_req_addr = head_entry.addr;
   assign mem_req_tag = head_entry.tag;
   assign mem_req_store_data = head_entry.data;
   assign mem_req_opcode = head_entry.opcode;
   assign mem_req_pc = head_entry.pc;

   // push and response together cancel out
   always_comb
   begin
      n_inflight = r_inflight;
      if (l2_req_valid && !mem_rsp_valid)
         n_inflight = r_inflight + 1'b1;
      else if (!l2_req_valid && mem_rsp_valid)
         n_inflight = r_inflight - 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         r_inflight <= '0;
      else
         r_inflight <= n_inflight;
   end

   assign inflight = r_inflight;

endmodule

// File: hdl/uncore_top.sv
`timescale 1ns/1ns

module uncore_top (
   input  logic                   clk,
   input  logic                   reset,

   // flush coordination
   input  logic                   flush_req_l1i,
   input  logic                   flush_req_l1d,
   input  logic                   l1i_flush_complete,
   input  logic                   l1d_flush_complete,
   input  logic                   l2_flush_complete,
   output logic                   in_flush_mode,
   output logic                   flush_l2,

   // outbound requests from the level-two side
   input  logic                   l2_req_valid,
   input  uncore_pkg::pa_t         l2_req_addr,
   input  uncore_pkg::req_tag_t    l2_req_tag,
   input  uncore_pkg::cl_data_t    l2_req_store_data,
   input  uncore_pkg::mem_opcode_t l2_req_opcode,
   input  uncore_pkg::pc_t         l2_req_pc,

   // memory port
   output logic                   mem_req_valid,
   output uncore_pkg::pa_t         mem_req_addr,
   output uncore_pkg::req_tag_t    mem_req_tag,
   output uncore_pkg::cl_data_t    mem_req_store_data,
   output uncore_pkg::mem_opcode_t mem_req_opcode,
   output uncore_pkg::pc_t         mem_req_pc,
   input  logic                   mem_req_gnt,
   input  logic                   mem_rsp_valid,
   output uncore_pkg::inflight_t   inflight
);

   flush_sequencer u_flush_sequencer (
      .clk                (clk),
      .reset              (reset),
      .flush_req_l1i      (flush_req_l1i),
      .flush_req_l1d      (flush_req_l1d),
      .l1i_flush_complete (l1i_flush_complete),
      .l1d_flush_complete (l1d_flush_complete),
      .l2_flush_complete  (l2_flush_complete),
      .in_flush_mode      (in_flush_mode),
      .flush_l2           (flush_l2)
   );

   mem_req_queue u_mem_req_queue (
      .clk                (clk),
      .reset              (reset),
      .l2_req_valid       (l2_req_valid),
      .l2_req_addr        (l2_req_addr),
      .l2_req_tag         (l2_req_tag),
      .l2_req_store_data  (l2_req_store_data),
      .l2_req_opcode      (l2_req_opcode),
      .l2_req_pc          (l2_req_pc),
      .mem_req_gnt        (mem_req_gnt),
      .mem_rsp_valid      (mem_rsp_valid),
      .mem_req_valid      (mem_req_valid),
      .mem_req_addr       (mem_req_addr),
      .mem_req_tag        (mem_req_tag),
      .mem_req_store_data (mem_req_store_data),
      .mem_req_opcode     (mem_req_opcode),
      .mem_req_pc         (mem_req_pc),
      .inflight           (inflight)
   );

endmodule

// File: testbench/uncore_sva.sv
`timescale 1ns/1ns

module uncore_sva (
   input logic                  clk,
   input logic                  reset,
   input logic                  flush_l2,
   input logic                  in_flush_mode,
   input logic                  mem_req_valid,
   input uncore_pkg::inflight_t inflight
);

   // level-two flush start is a single cycle strobe
   flush_l2_pulse: assert property (@(posedge clk) disable iff (reset)
      flush_l2 |=> !flush_l2)
      else $error("flush_l2 held for more than one cycle");

   flush_l2_in_mode: assert property (@(posedge clk) disable iff (reset)
      flush_l2 |-> in_flush_mode)
      else $error("flush_l2 raised outside flush mode");

   idle_after_reset: assert property (@(posedge clk)
      $fell(reset) |-> !mem_req_valid && !in_flush_mode)
      else $error("queue or flush mode active after reset");

   // going past the queue depth or below zero wraps the count
   inflight_bound: assert property (@(posedge clk) disable iff (reset)
      !($past(inflight) == '1 && inflight == '0)
      && !($past(inflight) == '0 && inflight == '1))
      else $error("inflight wrapped past its range");

endmodule

bind uncore_top uncore_sva u_sva (.*);

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
   output logic clk,
   output logic reset
);

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // held for eight rising edges, released just after the last one
   initial
   begin
      reset = 1'b1;
      repeat (8) @(posedge clk);
      #2;
      reset = 1'b0;
   end

endmodule

// File: testbench/tb_uncore.sv
`timescale 1ns/1ns

module tb_uncore;

   typedef struct packed {
      uncore_pkg::pa_t         addr;
      uncore_pkg::req_tag_t    tag;
      uncore_pkg::cl_data_t    data;
      uncore_pkg::mem_opcode_t opcode;
      uncore_pkg::pc_t         pc;
   } req_t;

   logic clk, reset;
   logic flush_req_l1i, flush_req_l1d, l1i_flush_complete, l1d_flush_complete;
   logic l2_flush_complete, in_flush_mode, flush_l2;
   logic l2_req_valid, mem_req_valid, mem_req_gnt, mem_rsp_valid;
   uncore_pkg::pa_t l2_req_addr, mem_req_addr;
   uncore_pkg::req_tag_t l2_req_tag, mem_req_tag;
   uncore_pkg::cl_data_t l2_req_store_data, mem_req_store_data;
   uncore_pkg::mem_opcode_t l2_req_opcode, mem_req_opcode;
   uncore_pkg::pc_t l2_req_pc, mem_req_pc;
   uncore_pkg::inflight_t inflight;

   // expected queue contents, oldest first
   req_t pending[$];
   integer seed = 32'hea1e_c56f;
   int errors = 0;
   int cycles = 0;

   tb_clock_gen u_clock_gen (.clk(clk), .reset(reset));

   uncore_top u_dut (.*);

   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   task automatic report_mismatch(input string name, input logic [127:0] got, exp);
      errors++;
      $display("ERR %s got %0h expected %0h", name, got, exp);
   endtask

   task automatic check_bit(input string name, input logic got, exp);
      if (got !== exp)
         report_mismatch(name, 128'(got), 128'(exp));
   endtask

   task automatic check_addr(input string name, input uncore_pkg::pa_t got, exp);
      if (got !== exp)
         report_mismatch(name, 128'(got), 128'(exp));
   endtask

   task automatic check_tag(input string name, input uncore_pkg::req_tag_t got, exp);
      if (got !== exp)
         report_mismatch(name, 128'(got), 128'(exp));
   endtask

   task automatic check_data(input string name, input uncore_pkg::cl_data_t got, exp);
      if (got !== exp)
         report_mismatch(name, got, exp);
   endtask

   task automatic check_opcode(input string name, input uncore_pkg::mem_opcode_t got, exp);
      if (got !== exp)
         report_mismatch(name, 128'(got), 128'(exp));
   endtask

   task automatic check_pc(input string name, input uncore_pkg::pc_t got, exp);
      if (got !== exp)
         report_mismatch(name, 128'(got), 128'(exp));
   endtask

   task automatic check_count(input string name, input uncore_pkg::inflight_t got, exp);
      if (got !== exp)
         report_mismatch(name, 128'(got), 128'(exp));
   endtask

   task automatic start_flush(input logic req_i, req_d);
      flush_req_l1i = req_i;
      flush_req_l1d = req_d;
      next_cycle();
      flush_req_l1i = 1'b0;
      flush_req_l1d = 1'b0;
      check_bit("in_flush_mode", in_flush_mode, 1'b1);
   endtask

   // one idle cycle, then a completion pulse
   task automatic send_l1_done(input logic done_i, done_d, expect_l2);
      next_cycle();
      l1i_flush_complete = done_i;
      l1d_flush_complete = done_d;
      next_cycle();
      l1i_flush_complete = 1'b0;
      l1d_flush_complete = 1'b0;
      check_bit("flush_l2", flush_l2, expect_l2);
   endtask

   task automatic end_flush();
      next_cycle();
      check_bit("flush_l2", flush_l2, 1'b0);
      check_bit("in_flush_mode", in_flush_mode, 1'b1);
      l2_flush_complete = 1'b1;
      next_cycle();
      l2_flush_complete = 1'b0;
      check_bit("in_flush_mode", in_flush_mode, 1'b0);
   endtask

   task automatic drive_random_req();
      req_t r;
      r.addr = $random(seed);
      r.tag = uncore_pkg::req_tag_t'($random(seed));
      r.data = {$random(seed), $random(seed), $random(seed), $random(seed)};
      r.opcode = uncore_pkg::mem_opcode_t'($random(seed));
      r.pc = {$random(seed), $random(seed)};
      {l2_req_addr, l2_req_tag, l2_req_store_data, l2_req_opcode, l2_req_pc} = r;
      l2_req_valid = 1'b1;
      pending.push_back(r);
   endtask

   task automatic check_head();
      check_bit("mem_req_valid", mem_req_valid, 1'b1);
      check_addr("mem_req_addr", mem_req_addr, pending[0].addr);
      check_tag("mem_req_tag", mem_req_tag, pending[0].tag);
      check_data("mem_req_store_data", mem_req_store_data, pending[0].data);
      check_opcode("mem_req_opcode", mem_req_opcode, pending[0].opcode);
      check_pc("mem_req_pc", mem_req_pc, pending[0].pc);
   endtask

   // grant every entry in order, with an idle cycle between grants if gap
   task automatic drain_queue(input logic gap);
      while (pending.size() > 0)
      begin
         check_head();
         mem_req_gnt = 1'b1;
         next_cycle();
         mem_req_gnt = 1'b0;
         pending.delete(0);
         if (gap)
            next_cycle();
      end
      check_bit("mem_req_valid", mem_req_valid, 1'b0);
   endtask

   task automatic return_responses(input int count);
      int n;
      mem_rsp_valid = 1'b1;
      for (n = count - 1; n >= 0; n--)
      begin
         next_cycle();
         check_count("inflight", inflight, uncore_pkg::inflight_t'(n));
      end
      mem_rsp_valid = 1'b0;
   endtask

   task automatic test_reset_state();
      check_bit("in_flush_mode", in_flush_mode, 1'b0);
      check_bit("flush_l2", flush_l2, 1'b0);
      check_bit("mem_req_valid", mem_req_valid, 1'b0);
      check_count("inflight", inflight, 3'd0);
   endtask

   task automatic test_dual_flush();
      start_flush(1'b1, 1'b1);
      send_l1_done(1'b0, 1'b1, 1'b0);
      send_l1_done(1'b1, 1'b0, 1'b1);
      end_flush();
      start_flush(1'b1, 1'b1);
      send_l1_done(1'b1, 1'b0, 1'b0);
      send_l1_done(1'b0, 1'b1, 1'b1);
      end_flush();
      start_flush(1'b1, 1'b1);
      send_l1_done(1'b1, 1'b1, 1'b1);
      end_flush();
   endtask

   // the other cache's completion must not start the level-two flush
   task automatic test_single_flush();
      start_flush(1'b1, 1'b0);
      send_l1_done(1'b0, 1'b1, 1'b0);
      send_l1_done(1'b1, 1'b0, 1'b1);
      end_flush();
      start_flush(1'b0, 1'b1);
      send_l1_done(1'b1, 1'b0, 1'b0);
      send_l1_done(1'b0, 1'b1, 1'b1);
      end_flush();
   endtask

   task automatic test_queue_order();
      int n;
      for (n = 0; n < 5; n++)
      begin
         drive_random_req();
         next_cycle();
         check_head();
      end
      l2_req_valid = 1'b0;
      check_count("inflight", inflight, 3'd5);
      drain_queue(1'b1);
      return_responses(5);
   endtask

   task automatic test_inflight();
      int n;
      for (n = 1; n <= 3; n++)
      begin
         drive_random_req();
         next_cycle();
         check_count("inflight", inflight, uncore_pkg::inflight_t'(n));
      end
      drive_random_req();
      mem_rsp_valid = 1'b1;
      next_cycle();
      l2_req_valid = 1'b0;
      check_count("inflight", inflight, 3'd3);
      return_responses(3);
      drain_queue(1'b0);
   endtask

   task automatic test_push_during_pop();
      drive_random_req();
      next_cycle();
      check_head();
      drive_random_req();
      mem_req_gnt = 1'b1;
      next_cycle();
      l2_req_valid = 1'b0;
      mem_req_gnt = 1'b0;
      pending.delete(0);
      check_head();
      drain_queue(1'b0);
      return_responses(2);
   endtask

   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= 2000)
      begin
         $display("timeout after %0d cycles, errors: %0d", cycles, errors);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   initial
   begin
      {flush_req_l1i, flush_req_l1d, l1i_flush_complete, l1d_flush_complete} = '0;
      l2_flush_complete = 1'b0;
      {l2_req_valid, mem_req_gnt, mem_rsp_valid} = '0;
      {l2_req_addr, l2_req_tag, l2_req_store_data, l2_req_opcode, l2_req_pc} = '0;
      @(negedge reset);
      test_reset_state();
      test_dual_flush();
      test_single_flush();
      test_queue_order();
      test_inflight();
      test_push_during_pop();
      $display("errors: %0d", errors);
      if (errors == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

// File: sources.f
+incdir+hdl
hdl/uncore_pkg.sv
hdl/flush_sequencer.sv
hdl/mem_req_queue.sv
hdl/uncore_top.sv
testbench/uncore_sva.sv
testbench/tb_clock_gen.sv
testbench/tb_uncore.sv

// File: run.sh
#!/bin/sh
# build and run the uncore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
   --top-module tb_uncore -f sources.f -o tb_uncore
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

output=$(./obj_dir/tb_uncore)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -q "^TESTBENCH PASSED$"; then
   exit 0
fi
exit 1
